//--- im2col_spc.f
hdl/im2col_pkg.sv
hdl/im2col_cfg_regs.sv
hdl/im2col_param_gen.sv
hdl/im2col_desc_fifo.sv
hdl/im2col_dma_prog.sv
hdl/im2col_spc.sv
bench/im2col_spc_chk.sv
bench/im2col_spc_tb.sv

//--- bench/im2col_spc_tb.sv
module im2col_spc_tb;

  import im2col_pkg::*;

  localparam int unsigned CLK_PERIOD = 40;
  localparam int unsigned DRV_DELAY  = 5;
  localparam int unsigned SEED       = 68941;
  // kernel elements over all tests: 4 + 9 + 9 + 9
  localparam int unsigned TOTAL_ELEMS    = 31;
  localparam int unsigned TIMEOUT_CYCLES = 2000 * TOTAL_ELEMS;

  logic       clk_i;
  logic       rst_ni;
  logic       cfg_we_i;
  logic [3:0] cfg_addr_i;
  cfg_word_u  cfg_wdata_i;
  logic       dma_req_o;
  word_t      dma_addr_o;
  word_t      dma_wdata_o;
  logic       dma_ack_i;
  logic       dma_done_i;
  logic       busy_o;
  logic       done_int_o;

  // expected DMA writes in order
  word_t       exp_addr [$];
  word_t       exp_data [$];
  int unsigned errors;
  int unsigned checks;
  int unsigned assert_fails;
  int unsigned done_cnt;
  int unsigned ack_min;
  int unsigned ack_max;
  int unsigned done_min;
  int unsigned done_max;
  int unsigned done_wait;
  word_t       cur_ch;
  event        launched;

  im2col_spc #(
    .DescDepth (4)
  ) im2col_spc_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .dma_req_o   (dma_req_o),
    .dma_addr_o  (dma_addr_o),
    .dma_wdata_o (dma_wdata_o),
    .dma_ack_i   (dma_ack_i),
    .dma_done_i  (dma_done_i),
    .busy_o      (busy_o),
    .done_int_o  (done_int_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  // one clock later, past the edge where outputs have settled
  task automatic wait_cycle();
    @(posedge clk_i);
    #DRV_DELAY;
  endtask

  task automatic check_value(string name, word_t got, word_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic expect_write(word_t addr, word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic check_write(word_t addr, word_t data);
    checks++;
    assert (exp_addr.size() > 0) else begin
      errors++;
      $display("at %0t an unexpected DMA write went to 0x%08h", $time, addr);
    end
    if (exp_addr.size() > 0) begin
      check_value("dma_addr_o", addr, exp_addr.pop_front());
      check_value("dma_wdata_o", data, exp_data.pop_front());
    end
  endtask

  // expected write sequence built from the geometry rules
  task automatic expect_job(word_t src, word_t dst, word_t ch, int unsigned w,
                            int unsigned h, int unsigned k, int unsigned s);
    int unsigned ow;
    int unsigned oh;
    int unsigned kh;
    int unsigned kw;
    ow = ((w - k) >> s) + 1;
    oh = ((h - k) >> s) + 1;
    expect_write(ch + DMA_DIM_CONFIG_OFF, 32'd2);
    expect_write(ch + DMA_DATA_TYPE_OFF, 32'd0);
    for (kh = 0; kh < k; kh++) begin
      for (kw = 0; kw < k; kw++) begin
        expect_write(ch + DMA_SRC_PTR_OFF, src + 4 * (kh * w + kw));
        expect_write(ch + DMA_DST_PTR_OFF, dst + 4 * (kh * k + kw) * ow * oh);
        expect_write(ch + DMA_SRC_INC_D1_OFF, 32'd4 << s);
        expect_write(ch + DMA_SRC_INC_D2_OFF, (4 * w) << s);
        expect_write(ch + DMA_DST_INC_D1_OFF, 32'd4);
        expect_write(ch + DMA_DST_INC_D2_OFF, 32'd4);
        expect_write(ch + DMA_SIZE_D2_OFF, oh);
        expect_write(ch + DMA_SIZE_D1_OFF, ow);
      end
    end
  endtask

  task automatic cfg_write(logic [3:0] addr, word_t data);
    @(posedge clk_i);
    #DRV_DELAY;
    cfg_we_i        = 1'b1;
    cfg_addr_i      = addr;
    cfg_wdata_i.raw = data;
    @(posedge clk_i);
    #DRV_DELAY;
    cfg_we_i = 1'b0;
  endtask

  task automatic run_job(word_t src, word_t dst, word_t ch, int unsigned w, int unsigned h,
                         int unsigned k, int unsigned s, bit restart_mid);
    cfg_word_u g;
    g.raw              = '0;
    g.geom.img_w       = 8'(w);
    g.geom.img_h       = 8'(h);
    g.geom.ker_k       = 4'(k);
    g.geom.stride_log2 = 2'(s);
    cur_ch             = ch;
    cfg_write(CFG_SRC_PTR, src);
    cfg_write(CFG_DST_PTR, dst);
    cfg_write(CFG_CH_OFFSET, ch);
    cfg_write(CFG_GEOM, g.raw);
    expect_job(src, dst, ch, w, h, k, s);
    done_cnt = 0;
    cfg_write(CFG_START, '0);
    check_value("busy_o", busy_o, 1);
    if (restart_mid) begin
      // second start lands while descriptors are still in flight
      while (exp_addr.size() > 40) begin
        wait_cycle();
      end
      cfg_write(CFG_START, '0);
      check_value("busy_o", busy_o, 1);
    end
    while (!done_int_o) begin
      wait_cycle();
    end
    check_value("busy_o", busy_o, 0);
    check_value("dma_done_i pulses", done_cnt, k * k);
    checks++;
    assert (exp_addr.size() == 0) else begin
      errors++;
      $display("job ended with %0d DMA writes still missing", exp_addr.size());
    end
    // flag is sticky and no late writes show up
    repeat (20) begin
      wait_cycle();
      check_value("done_int_o", done_int_o, 1);
    end
    cfg_write(CFG_IRQ_CLR, '0);
    check_value("done_int_o", done_int_o, 0);
  endtask

  task automatic test_reset_state();
    check_value("dma_req_o", dma_req_o, 0);
    check_value("busy_o", busy_o, 0);
    check_value("done_int_o", done_int_o, 0);
  endtask

  task automatic test_small_job();
    run_job(32'h0001_0000, 32'h0002_0000, 32'h0000_1000, 4, 4, 2, 0, 1'b0);
  endtask

  task automatic test_strided_job();
    run_job(32'h0004_0100, 32'h0008_0000, 32'h0000_2400, 7, 5, 3, 1, 1'b0);
  endtask

  task automatic test_back_pressure();
    ack_min  = 4;
    ack_max  = 8;
    done_min = 30;
    done_max = 30;
    run_job(32'h0010_0000, 32'h0020_0000, 32'h0000_3000, 8, 8, 3, 0, 1'b0);
    ack_min  = 0;
    ack_max  = 3;
    done_min = 1;
    done_max = 6;
  endtask

  task automatic test_restart_and_irq();
    run_job(32'h0030_0040, 32'h0040_0000, 32'h0000_1000, 6, 6, 3, 0, 1'b1);
  endtask

  // DMA channel model, acks each register write after a random wait
  initial begin : dma_responder
    int unsigned delay;
    word_t       wr_addr;
    word_t       wr_data;
    void'($urandom(SEED));
    forever begin
      wait_cycle();
      if (dma_req_o) begin
        delay = $urandom_range(ack_max, ack_min);
        repeat (delay) begin
          wait_cycle();
        end
        // address and data are held until the ack is taken
        wr_addr   = dma_addr_o;
        wr_data   = dma_wdata_o;
        dma_ack_i = 1'b1;
        wait_cycle();
        dma_ack_i = 1'b0;
        check_write(wr_addr, wr_data);
        if (wr_addr == cur_ch + DMA_SIZE_D1_OFF) begin
          done_wait = $urandom_range(done_max, done_min);
          -> launched;
        end
      end
    end
  end

  initial begin : done_pulser
    forever begin
      @(launched);
      repeat (done_wait) @(posedge clk_i);
      #DRV_DELAY;
      dma_done_i = 1'b1;
      done_cnt++;
      @(posedge clk_i);
      #DRV_DELAY;
      dma_done_i = 1'b0;
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main
    errors       = 0;
    checks       = 0;
    assert_fails = 0;
    done_cnt     = 0;
    ack_min      = 0;
    ack_max      = 3;
    done_min     = 1;
    done_max     = 6;
    done_wait    = 1;
    cur_ch       = '0;
    rst_ni       = 1'b0;
    cfg_we_i     = 1'b0;
    cfg_addr_i   = '0;
    cfg_wdata_i  = '0;
    dma_ack_i    = 1'b0;
    dma_done_i   = 1'b0;
    repeat (2) @(posedge clk_i);
    #DRV_DELAY;
    rst_ni = 1'b1;
    test_reset_state();
    test_small_job();
    test_strided_job();
    test_back_pressure();
    test_restart_and_irq();
    assert_fails = im2col_spc_i.im2col_spc_chk_i.fail_cnt;
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- bench/im2col_spc_chk.sv
module im2col_spc_chk (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              req_i,
  input logic              ack_i,
  input im2col_pkg::word_t addr_i,
  input im2col_pkg::word_t wdata_i,
  input logic              busy_i,
  input logic              done_int_i
);

  int unsigned fail_cnt = 0;

  // a pending write keeps its address and data until acknowledged
  req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && !ack_i |=> req_i && $stable(addr_i) && $stable(wdata_i))
    else begin
      fail_cnt++;
      $error("DMA request dropped or changed before its acknowledge");
    end

  // no bus traffic outside a job
  req_in_job_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !busy_i |-> !req_i)
    else begin
      fail_cnt++;
      $error("DMA request raised while the controller is not busy");
    end

  // done flag rises together with the end of busy
  done_after_busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(done_int_i) |-> $fell(busy_i))
    else begin
      fail_cnt++;
      $error("done interrupt rose without busy falling");
    end

endmodule

bind im2col_spc im2col_spc_chk im2col_spc_chk_i (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .req_i      (dma_req_o),
  .ack_i      (dma_ack_i),
  .addr_i     (dma_addr_o),
  .wdata_i    (dma_wdata_o),
  .busy_i     (busy_o),
  .done_int_i (done_int_o)
);

//--- hdl/im2col_spc.sv
module im2col_spc #(
  parameter int unsigned DescDepth = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cfg_we_i,
  input  logic [3:0]            cfg_addr_i,
  input  im2col_pkg::cfg_word_u cfg_wdata_i,
  output logic                  dma_req_o,
  output im2col_pkg::word_t     dma_addr_o,
  output im2col_pkg::word_t     dma_wdata_o,
  input  logic                  dma_ack_i,
  input  logic                  dma_done_i,
  output logic                  busy_o,
  output logic                  done_int_o
);

  import im2col_pkg::*;

  logic  start;
  logic  job_done;
  word_t src_ptr;
  word_t dst_ptr;
  word_t ch_offset;
  geom_t geom;
  logic  push;
  logic  pop;
  logic  full;
  logic  empty;
  logic  gen_done;
  desc_t desc_in;
  desc_t desc_head;

  im2col_cfg_regs im2col_cfg_regs_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .job_done_i  (job_done),
    .start_o     (start),
    .busy_o      (busy_o),
    .done_int_o  (done_int_o),
    .src_ptr_o   (src_ptr),
    .dst_ptr_o   (dst_ptr),
    .ch_offset_o (ch_offset),
    .geom_o      (geom)
  );

  im2col_param_gen im2col_param_gen_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start),
    .src_ptr_i  (src_ptr),
    .dst_ptr_i  (dst_ptr),
    .geom_i     (geom),
    .full_i     (full),
    .push_o     (push),
    .desc_o     (desc_in),
    .gen_done_o (gen_done)
  );

  im2col_desc_fifo #(
    .Depth (DescDepth)
  ) im2col_desc_fifo_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (push),
    .data_i  (desc_in),
    .pop_i   (pop),
    .data_o  (desc_head),
    .full_o  (full),
    .empty_o (empty)
  );

  im2col_dma_prog im2col_dma_prog_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start),
    .ch_offset_i (ch_offset),
    .desc_i      (desc_head),
    .empty_i     (empty),
    .gen_done_i  (gen_done),
    .dma_ack_i   (dma_ack_i),
    .dma_done_i  (dma_done_i),
    .pop_o       (pop),
    .job_done_o  (job_done),
    .dma_req_o   (dma_req_o),
    .dma_addr_o  (dma_addr_o),
    .dma_wdata_o (dma_wdata_o)
  );

endmodule

//--- hdl/im2col_dma_prog.sv
module im2col_dma_prog (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start_i,
  input  im2col_pkg::word_t ch_offset_i,
  input  im2col_pkg::desc_t desc_i,
  input  logic              empty_i,
  input  logic              gen_done_i,
  input  logic              dma_ack_i,
  input  logic              dma_done_i,
  output logic              pop_o,
  output logic              job_done_o,
  output logic              dma_req_o,
  output im2col_pkg::word_t dma_addr_o,
  output im2col_pkg::word_t dma_wdata_o
);

  import im2col_pkg::*;

  typedef enum logic [3:0] {
    IDLE,
    WR_DIM,
    WR_DTYPE,
    WR_SRC_PTR,
    WR_DST_PTR,
    WR_INC_SRC_D1,
    WR_INC_SRC_D2,
    WR_INC_DST_D1,
    WR_INC_DST_D2,
    WR_SIZE_D2,
    WR_SIZE_D1,
    POP
  } state_e;

  state_e     state_q;
  state_e     state_d;
  state_e     next_wr;
  logic [7:0] reg_off;
  logic       hdr_pending_q;
  logic       ch_free_q;
  logic       job_q;

  // register offset, data and successor for each write
  always_comb begin
    dma_req_o   = 1'b1;
    reg_off     = '0;
    dma_wdata_o = '0;
    next_wr     = IDLE;
    unique case (state_q)
      WR_DIM: begin
        reg_off     = DMA_DIM_CONFIG_OFF;
        dma_wdata_o = 32'd2;
        next_wr     = WR_DTYPE;
      end
      WR_DTYPE: begin
        // 32-bit words only
        reg_off     = DMA_DATA_TYPE_OFF;
        dma_wdata_o = 32'd0;
        next_wr     = WR_SRC_PTR;
      end
      WR_SRC_PTR: begin
        reg_off     = DMA_SRC_PTR_OFF;
        dma_wdata_o = desc_i.src_ptr;
        next_wr     = WR_DST_PTR;
      end
      WR_DST_PTR: begin
        reg_off     = DMA_DST_PTR_OFF;
        dma_wdata_o = desc_i.dst_ptr;
        next_wr     = WR_INC_SRC_D1;
      end
      WR_INC_SRC_D1: begin
        reg_off     = DMA_SRC_INC_D1_OFF;
        dma_wdata_o = desc_i.inc_src_d1;
        next_wr     = WR_INC_SRC_D2;
      end
      WR_INC_SRC_D2: begin
        reg_off     = DMA_SRC_INC_D2_OFF;
        dma_wdata_o = desc_i.inc_src_d2;
        next_wr     = WR_INC_DST_D1;
      end
      WR_INC_DST_D1: begin
        // destination is written contiguously
        reg_off     = DMA_DST_INC_D1_OFF;
        dma_wdata_o = word_t'(WORD_BYTES);
        next_wr     = WR_INC_DST_D2;
      end
      WR_INC_DST_D2: begin
        reg_off     = DMA_DST_INC_D2_OFF;
        dma_wdata_o = word_t'(WORD_BYTES);
        next_wr     = WR_SIZE_D2;
      end
      WR_SIZE_D2: begin
        reg_off     = DMA_SIZE_D2_OFF;
        dma_wdata_o = {16'b0, desc_i.size_d2};
        next_wr     = WR_SIZE_D1;
      end
      WR_SIZE_D1: begin
        // this write launches the transfer
        reg_off     = DMA_SIZE_D1_OFF;
        dma_wdata_o = {16'b0, desc_i.size_d1};
        next_wr     = POP;
      end
      default: begin
        dma_req_o = 1'b0;
      end
    endcase
  end

  assign dma_addr_o = ch_offset_i + {24'b0, reg_off};
  assign pop_o      = (state_q == POP);
  assign job_done_o = job_q && gen_done_i && empty_i && ch_free_q && (state_q == IDLE);

  always_comb begin
    state_d = state_q;
    if (state_q == IDLE) begin
      if (!empty_i && ch_free_q) begin
        state_d = hdr_pending_q ? WR_DIM : WR_SRC_PTR;
      end
    end else if (state_q == POP) begin
      state_d = IDLE;
    end else if (dma_ack_i) begin
      state_d = next_wr;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      hdr_pending_q <= 1'b0;
      ch_free_q     <= 1'b1;
      job_q         <= 1'b0;
    end else begin
      state_q <= state_d;
      // header writes go out once per job
      if (start_i) begin
        hdr_pending_q <= 1'b1;
      end else if (state_q == WR_DTYPE && dma_ack_i) begin
        hdr_pending_q <= 1'b0;
      end
      if (start_i || dma_done_i) begin
        ch_free_q <= 1'b1;
      end else if (state_q == WR_SIZE_D1 && dma_ack_i) begin
        ch_free_q <= 1'b0;
      end
      if (start_i) begin
        job_q <= 1'b1;
      end else if (job_done_o) begin
        job_q <= 1'b0;
      end
    end
  end

endmodule

//--- hdl/im2col_desc_fifo.sv
module im2col_desc_fifo #(
  parameter int unsigned Depth = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              push_i,
  input  im2col_pkg::desc_t data_i,
  input  logic              pop_i,
  output im2col_pkg::desc_t data_o,
  output logic              full_o,
  output logic              empty_o
);

  import im2col_pkg::*;

  localparam int unsigned AddrW = $clog2(Depth);

  desc_t            mem_q [Depth];
  logic [AddrW-1:0] wr_ptr_q;
  logic [AddrW-1:0] rd_ptr_q;
  logic [AddrW:0]   count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == (AddrW + 1)'(Depth));
  assign empty_o = (count_q == '0);

  // overflow and underflow requests are ignored
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // fall-through head
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- hdl/im2col_param_gen.sv
module im2col_param_gen (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start_i,
  input  im2col_pkg::word_t src_ptr_i,
  input  im2col_pkg::word_t dst_ptr_i,
  input  im2col_pkg::geom_t geom_i,
  input  logic              full_i,
  output logic              push_o,
  output im2col_pkg::desc_t desc_o,
  output logic              gen_done_o
);

  import im2col_pkg::*;

  // values derived from the geometry at start
  logic [7:0]  w_span;
  logic [7:0]  h_span;
  logic [15:0] ow_d;
  logic [15:0] oh_d;
  word_t       row_bytes_d;
  word_t       plane_bytes_d;

  // latched job state
  word_t       src_row_q;
  word_t       src_cur_q;
  word_t       dst_cur_q;
  word_t       row_bytes_q;
  word_t       plane_bytes_q;
  word_t       inc_d1_q;
  word_t       inc_d2_q;
  logic [15:0] ow_q;
  logic [15:0] oh_q;
  logic [3:0]  ker_k_q;
  logic [3:0]  kh_q;
  logic [3:0]  kw_q;
  logic        active_q;
  logic        gen_done_q;
  logic        last_col;
  logic        last_elem;

  assign w_span        = geom_i.img_w - {4'b0, geom_i.ker_k};
  assign h_span        = geom_i.img_h - {4'b0, geom_i.ker_k};
  assign ow_d          = {8'b0, w_span >> geom_i.stride_log2} + 16'd1;
  assign oh_d          = {8'b0, h_span >> geom_i.stride_log2} + 16'd1;
  assign row_bytes_d   = {24'b0, geom_i.img_w} * word_t'(WORD_BYTES);
  assign plane_bytes_d = {16'b0, ow_d} * {16'b0, oh_d} * word_t'(WORD_BYTES);

  assign last_col  = (kw_q == ker_k_q - 4'd1);
  assign last_elem = last_col && (kh_q == ker_k_q - 4'd1);

  // stall on a full FIFO
  assign push_o     = active_q && !full_i;
  assign gen_done_o = gen_done_q;

  // kernel window walk, kw fastest
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      active_q   <= 1'b0;
      gen_done_q <= 1'b0;
      kh_q       <= '0;
      kw_q       <= '0;
    end else if (start_i) begin
      active_q   <= (geom_i.ker_k != 4'd0);
      gen_done_q <= (geom_i.ker_k == 4'd0);
      kh_q       <= '0;
      kw_q       <= '0;
    end else if (push_o) begin
      if (last_elem) begin
        active_q   <= 1'b0;
        gen_done_q <= 1'b1;
      end
      if (last_col) begin
        kw_q <= '0;
        kh_q <= kh_q + 4'd1;
      end else begin
        kw_q <= kw_q + 4'd1;
      end
    end
  end

  // running pointers replace the per-element multiplies
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      src_row_q     <= src_ptr_i;
      src_cur_q     <= src_ptr_i;
      dst_cur_q     <= dst_ptr_i;
      row_bytes_q   <= row_bytes_d;
      plane_bytes_q <= plane_bytes_d;
      inc_d1_q      <= word_t'(WORD_BYTES) << geom_i.stride_log2;
      inc_d2_q      <= row_bytes_d << geom_i.stride_log2;
      ow_q          <= ow_d;
      oh_q          <= oh_d;
      ker_k_q       <= geom_i.ker_k;
    end else if (push_o) begin
      dst_cur_q <= dst_cur_q + plane_bytes_q;
      if (last_col) begin
        src_row_q <= src_row_q + row_bytes_q;
        src_cur_q <= src_row_q + row_bytes_q;
      end else begin
        src_cur_q <= src_cur_q + word_t'(WORD_BYTES);
      end
    end
  end

  assign desc_o.src_ptr    = src_cur_q;
  assign desc_o.dst_ptr    = dst_cur_q;
  assign desc_o.inc_src_d1 = inc_d1_q;
  assign desc_o.inc_src_d2 = inc_d2_q;
  assign desc_o.size_d1    = ow_q;
  assign desc_o.size_d2    = oh_q;

endmodule

//--- hdl/im2col_cfg_regs.sv
module im2col_cfg_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cfg_we_i,
  input  logic [3:0]            cfg_addr_i,
  input  im2col_pkg::cfg_word_u cfg_wdata_i,
  input  logic                  job_done_i,
  output logic                  start_o,
  output logic                  busy_o,
  output logic                  done_int_o,
  output im2col_pkg::word_t     src_ptr_o,
  output im2col_pkg::word_t     dst_ptr_o,
  output im2col_pkg::word_t     ch_offset_o,
  output im2col_pkg::geom_t     geom_o
);

  import im2col_pkg::*;

  logic start_wr;
  logic irq_clr_wr;

  // a start while a job runs is dropped
  assign start_wr   = cfg_we_i && (cfg_addr_i == CFG_START) && !busy_o;
  assign irq_clr_wr = cfg_we_i && (cfg_addr_i == CFG_IRQ_CLR);

  // configuration words
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      src_ptr_o   <= '0;
      dst_ptr_o   <= '0;
      ch_offset_o <= '0;
      geom_o      <= '0;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        CFG_SRC_PTR: begin
          src_ptr_o <= cfg_wdata_i.raw;
        end
        CFG_DST_PTR: begin
          dst_ptr_o <= cfg_wdata_i.raw;
        end
        CFG_GEOM: begin
          geom_o      <= cfg_wdata_i.geom;
          // reserved bits always read back as zero
          geom_o.rsvd <= '0;
        end
        CFG_CH_OFFSET: begin
          ch_offset_o <= cfg_wdata_i.raw;
        end
        default: begin
        end
      endcase
    end
  end

  // start pulse and busy level
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      start_o <= 1'b0;
      busy_o  <= 1'b0;
    end else begin
      start_o <= start_wr;
      if (job_done_i) begin
        busy_o <= 1'b0;
      end else if (start_wr) begin
        busy_o <= 1'b1;
      end
    end
  end

  // sticky done flag, cleared only by software
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      done_int_o <= 1'b0;
    end else if (job_done_i) begin
      done_int_o <= 1'b1;
    end else if (irq_clr_wr) begin
      done_int_o <= 1'b0;
    end
  end

endmodule

//--- hdl/im2col_pkg.sv
package im2col_pkg;

  typedef logic [31:0] word_t;

  // image and kernel geometry, packed into one register word
  typedef struct packed {
    logic [9:0] rsvd;
    logic [1:0] stride_log2;
    logic [3:0] ker_k;
    logic [7:0] img_h;
    logic [7:0] img_w;
  } geom_t;

  // write data seen as a plain word or as the geometry fields
  typedef union packed {
    word_t raw;
    geom_t geom;
  } cfg_word_u;

  // one 2D DMA transaction
  typedef struct packed {
    word_t       src_ptr;
    word_t       dst_ptr;
    word_t       inc_src_d1;
    word_t       inc_src_d2;
    logic [15:0] size_d1;
    logic [15:0] size_d2;
  } desc_t;

  // configuration register addresses
  localparam logic [3:0] CFG_SRC_PTR   = 4'd0;
  localparam logic [3:0] CFG_DST_PTR   = 4'd1;
  localparam logic [3:0] CFG_GEOM      = 4'd2;
  localparam logic [3:0] CFG_CH_OFFSET = 4'd3;
  localparam logic [3:0] CFG_START     = 4'd4;
  localparam logic [3:0] CFG_IRQ_CLR   = 4'd5;

  // DMA channel register byte offsets
  localparam logic [7:0] DMA_SRC_PTR_OFF    = 8'h00;
  localparam logic [7:0] DMA_DST_PTR_OFF    = 8'h04;
  localparam logic [7:0] DMA_SIZE_D1_OFF    = 8'h0C;
  localparam logic [7:0] DMA_SIZE_D2_OFF    = 8'h10;
  localparam logic [7:0] DMA_SRC_INC_D1_OFF = 8'h18;
  localparam logic [7:0] DMA_SRC_INC_D2_OFF = 8'h1C;
  localparam logic [7:0] DMA_DST_INC_D1_OFF = 8'h20;
  localparam logic [7:0] DMA_DST_INC_D2_OFF = 8'h24;
  localparam logic [7:0] DMA_DATA_TYPE_OFF  = 8'h2C;
  localparam logic [7:0] DMA_DIM_CONFIG_OFF = 8'h34;

  localparam int unsigned WORD_BYTES = 4;

endpackage
